//--- hdl/sau_isa_pkg.sv
package sau_isa_pkg;

	// ========================================
	// Opcodes, values 13 to 31 are unimplemented
	// ========================================
	typedef enum logic [4:0] {
		OP_ADD   = 5'd0,
		OP_AND   = 5'd1,
		OP_OR    = 5'd2,
		OP_XOR   = 5'd3,
		OP_SUBF  = 5'd4,
		OP_SHIFT = 5'd5,
		OP_CNT   = 5'd6,
		OP_MOV   = 5'd7,
		OP_CMP   = 5'd8,
		OP_CHK   = 5'd9,
		OP_LOADA = 5'd10,
		OP_DIV   = 5'd11,
		OP_NOP   = 5'd12
	} opcode_t;

	// Sub-function codes, one set per opcode family
	typedef enum logic [2:0] {AF_ADD = 3'd0, AF_ABS = 3'd2} add_fn_t;
	typedef enum logic [2:0] {LF_PLAIN = 3'd0, LF_INV = 3'd1, LF_INVB = 3'd2} logic_fn_t;
	typedef enum logic [2:0] {
		SF_SLL = 3'd0,
		SF_SRL = 3'd1,
		SF_SRA = 3'd2,
		SF_ROL = 3'd3,
		SF_ROR = 3'd4
	} shift_fn_t;
	typedef enum logic [2:0] {CF_CLO = 3'd0, CF_CLZ = 3'd1, CF_POP = 3'd2, CF_CTZ = 3'd3} cnt_fn_t;
	typedef enum logic [2:0] {MF_CMOVZ = 3'd4, MF_CMOVNZ = 3'd5} mov_fn_t;
	typedef enum logic [2:0] {DF_QUOT = 3'd0, DF_REM = 3'd1} div_fn_t;

	// ========================================
	// Instruction word, 16 bits
	// ========================================
	typedef struct packed {
		opcode_t    opcode;	// [15:11]
		logic [2:0] fn;		// Sub-function or check kind
		logic       isimm;	// Second operand is imm
		logic [1:0] sc;		// LOADA scale
		logic [4:0] amt;	// Spare
	} instr_t;

endpackage

//--- hdl/sau_fault_pkg.sv
package sau_fault_pkg;

	// Fault causes reported with each result
	typedef enum logic [3:0] {
		FLT_NONE  = 4'd0,
		FLT_CHK   = 4'd1,
		FLT_DBZ   = 4'd2,
		FLT_UNIMP = 4'd3
	} cause_t;

	// Range checks of a against lower bound b and upper bound c
	// Bit 2 selects out-of-range, bit 1 an exclusive lower bound, bit 0 an inclusive upper
	typedef enum logic [2:0] {
		CHK_IN_GE_LT  = 3'd0,
		CHK_IN_GE_LE  = 3'd1,
		CHK_IN_GT_LT  = 3'd2,
		CHK_IN_GT_LE  = 3'd3,
		CHK_OUT_GE_LT = 3'd4,
		CHK_OUT_GE_LE = 3'd5,
		CHK_OUT_GT_LT = 3'd6,
		CHK_OUT_GT_LE = 3'd7
	} chk_kind_t;

endpackage

//--- hdl/sau_op_if.sv
`timescale 1ns/1ps

interface sau_op_if #(
	parameter int WID = 64
);
	import sau_isa_pkg::*;

	instr_t         ir;	// Issued instruction
	logic [WID-1:0] a;
	logic [WID-1:0] b;
	logic [WID-1:0] c;
	logic [WID-1:0] imm;

	// Sequencer holds the operands for the whole operation
	modport src (output ir, a, b, c, imm);

	modport alu (input ir, a, b, c, imm);
	modport div (input ir, a, b, imm);	// Divider has no use for c

endinterface

//--- hdl/sau_bitcnt.sv
`timescale 1ns/1ps

module sau_bitcnt #(
	parameter int WID = 64
) (
	input  logic [WID-1:0] x,
	output logic [WID-1:0] lead_ones,
	output logic [WID-1:0] lead_zeros,
	output logic [WID-1:0] trail_zeros,
	output logic [WID-1:0] pop
);

	logic [WID-1:0] x_rev;

	// Length of the run of bitval from the MSB down
	function automatic logic [WID-1:0] lead_run(input logic [WID-1:0] v, input logic bitval);
		logic [WID-1:0] n;
		logic           stop;
		n = '0;
		stop = 1'b0;
		for (int i = WID - 1; i >= 0; i--)
		begin
			if (!stop && v[i] == bitval)
				n = n + 1'b1;
			else
				stop = 1'b1;
		end
		return n;
	endfunction

	assign x_rev = {<<{x}};	// Trailing run becomes a leading run

	assign lead_ones   = lead_run(x, 1'b1);
	assign lead_zeros  = lead_run(x, 1'b0);
	assign trail_zeros = lead_run(x_rev, 1'b0);

	always_comb
	begin
		pop = '0;
		for (int i = 0; i < WID; i++)
			pop = pop + x[i];
	end

endmodule

//--- hdl/sau_alu.sv
`timescale 1ns/1ps

module sau_alu #(
	parameter int WID = 64
) (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  go,
	sau_op_if.alu                 op,
	output logic [WID-1:0]        res,
	output sau_fault_pkg::cause_t exc
);
	import sau_isa_pkg::*;
	import sau_fault_pkg::*;

	localparam int SHW = $clog2(WID);
	localparam logic [WID-1:0] DEAD = {(WID/16){16'hDEAD}};

	logic [WID-1:0]   bo;		// Second operand
	logic [WID-1:0]   sum;
	logic [SHW-1:0]   shamt;
	logic [2*WID-1:0] rol2;
	logic [2*WID-1:0] ror2;
	logic [WID-1:0]   lb;
	logic [WID-1:0]   lr;
	logic [WID-1:0]   lead_ones;
	logic [WID-1:0]   lead_zeros;
	logic [WID-1:0]   trail_zeros;
	logic [WID-1:0]   pop;
	logic             lo_ge;
	logic             lo_gt;
	logic             hi_lt;
	logic             hi_le;
	logic             chk_pass;
	logic [WID-1:0]   bus;
	cause_t           exc_d;

	assign bo    = op.ir.isimm ? op.imm : op.b;
	assign sum   = op.a + bo;
	assign shamt = bo[SHW-1:0];
	assign rol2  = {op.a, op.a} << shamt;	// Upper half is the left rotate
	assign ror2  = {op.a, op.a} >> shamt;	// Lower half is the right rotate

	sau_bitcnt #(.WID(WID)) u_bitcnt (
		.x           (op.a),
		.lead_ones   (lead_ones),
		.lead_zeros  (lead_zeros),
		.trail_zeros (trail_zeros),
		.pop         (pop)
	);

	// ========================================
	// Logic families share one gate stage
	// ========================================
	always_comb
	begin
		lb = (op.ir.fn == LF_INVB) ? ~bo : bo;
		case (op.ir.opcode)
			OP_AND: lr = op.a & lb;
			OP_OR: lr = op.a | lb;
			default: lr = op.a ^ lb;
		endcase
	end

	// Unsigned bounds compare
	assign lo_ge = op.a >= op.b;
	assign lo_gt = op.a > op.b;
	assign hi_lt = op.a < op.c;
	assign hi_le = op.a <= op.c;

	always_comb
	begin
		case (chk_kind_t'(op.ir.fn))
			CHK_IN_GE_LT: chk_pass = lo_ge && hi_lt;
			CHK_IN_GE_LE: chk_pass = lo_ge && hi_le;
			CHK_IN_GT_LT: chk_pass = lo_gt && hi_lt;
			CHK_IN_GT_LE: chk_pass = lo_gt && hi_le;
			CHK_OUT_GE_LT: chk_pass = !(lo_ge && hi_lt);
			CHK_OUT_GE_LE: chk_pass = !(lo_ge && hi_le);
			CHK_OUT_GT_LT: chk_pass = !(lo_gt && hi_lt);
			default: chk_pass = !(lo_gt && hi_le);
		endcase
	end

	// ========================================
	// Result mux
	// ========================================
	always_comb
	begin
		bus = '0;
		exc_d = FLT_NONE;
		case (op.ir.opcode)
			OP_ADD:
				case (op.ir.fn)
					AF_ADD: bus = sum;
					AF_ABS: bus = sum[WID-1] ? -sum : sum;
					default: bus = '0;
				endcase
			OP_AND, OP_OR, OP_XOR:
				case (op.ir.fn)
					LF_PLAIN, LF_INVB: bus = lr;
					LF_INV: bus = ~lr;
					default: bus = '0;
				endcase
			OP_SUBF: bus = bo - op.a;	// Reverse subtract
			OP_SHIFT:
				case (op.ir.fn)
					SF_SLL: bus = op.a << shamt;
					SF_SRL: bus = op.a >> shamt;
					SF_SRA: bus = $signed(op.a) >>> shamt;
					SF_ROL: bus = rol2[2*WID-1:WID];
					SF_ROR: bus = ror2[WID-1:0];
					default: bus = '0;
				endcase
			OP_CNT:
				case (op.ir.fn)
					CF_CLO: bus = lead_ones;
					CF_CLZ: bus = lead_zeros;
					CF_POP: bus = pop;
					CF_CTZ: bus = trail_zeros;
					default: bus = '0;
				endcase
			OP_MOV:
				case (op.ir.fn)
					MF_CMOVZ: bus = (op.a == '0) ? bo : op.c;
					MF_CMOVNZ: bus = (op.a != '0) ? bo : op.c;
					default: bus = '0;
				endcase
			OP_CMP:
			begin
				bus[0] = op.a == bo;
				bus[1] = $signed(op.a) < $signed(bo);
				bus[2] = op.a < bo;
			end
			OP_CHK:
			begin
				bus[0] = chk_pass;	// One on pass
				if (!chk_pass)
					exc_d = FLT_CHK;
			end
			OP_LOADA: bus = op.a + op.imm + (op.b << op.ir.sc);
			OP_NOP: bus = op.c;
			OP_DIV: bus = '0;	// Handled by the divider
			default:
			begin
				bus = DEAD;
				exc_d = FLT_UNIMP;
			end
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			res <= '0;
			exc <= FLT_NONE;
		end
		else if (go)
		begin
			res <= bus;
			exc <= exc_d;
		end
	end

endmodule

//--- hdl/sau_divider.sv
`timescale 1ns/1ps

module sau_divider #(
	parameter int WID = 64
) (
	input  logic           clk,
	input  logic           rst,
	input  logic           start,
	input  logic           step,
	sau_op_if.div          op,
	output logic [WID-1:0] quot,
	output logic [WID-1:0] rem,
	output logic           dbz
);

	logic [WID-1:0] bo;
	logic [WID-1:0] dvs;	// Divisor
	logic [WID-1:0] q;	// Dividend shifting out, quotient shifting in
	logic [WID-1:0] r;	// Partial remainder
	logic [WID:0]   part;
	logic [WID:0]   diff;
	logic           ge;

	assign bo   = op.ir.isimm ? op.imm : op.b;
	assign part = {r, q[WID-1]};
	assign diff = part - {1'b0, dvs};
	assign ge   = part >= {1'b0, dvs};	// Always true for a zero divisor

	always_ff @(posedge clk)
	begin
		if (start)
		begin
			q <= op.a;
			r <= '0;
			dvs <= bo;
		end
		else if (step)
		begin
			q <= {q[WID-2:0], ge};
			r <= ge ? diff[WID-1:0] : part[WID-1:0];
		end
	end

	always_ff @(posedge clk)
	begin
		if (rst)
			dbz <= 1'b0;
		else if (start)
			dbz <= (bo == '0);
	end

	assign quot = q;
	assign rem  = r;

endmodule

//--- hdl/sau_step_counter.sv
`timescale 1ns/1ps

module sau_step_counter #(
	parameter int WID = 64
) (
	input  logic clk,
	input  logic rst,
	input  logic load,
	input  logic step,
	output logic last
);

	localparam int CW = $clog2(WID) + 1;	// Must hold WID itself

	logic [CW-1:0] cnt;

	always_ff @(posedge clk)
	begin
		if (rst)
			cnt <= '0;
		else if (load)
			cnt <= CW'(WID);
		else if (step && cnt != '0)
			cnt <= cnt - 1'b1;
	end

	// Final iteration
	assign last = step && (cnt == CW'(1));

endmodule

//--- hdl/sau_seq.sv
`timescale 1ns/1ps

module sau_seq #(
	parameter int WID = 64
) (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 ld,
	input  sau_isa_pkg::instr_t  ir_in,
	input  logic [WID-1:0]       a_in,
	input  logic [WID-1:0]       b_in,
	input  logic [WID-1:0]       c_in,
	input  logic [WID-1:0]       imm_in,
	input  logic                 last,
	sau_op_if.src                op,
	output logic                 alu_go,
	output logic                 div_start,
	output logic                 div_step,
	output logic                 sel_div,
	output logic                 done,
	output logic                 busy
);
	import sau_isa_pkg::*;

	typedef enum logic [2:0] {IDLE, EXEC, DSTART, DSTEP, DFIN} state_t;

	state_t state;
	state_t state_nx;
	logic   accept;
	logic   is_div;

	assign busy   = (state != IDLE);
	assign accept = ld && !busy;	// ld while busy is dropped
	assign is_div = (ir_in.opcode == OP_DIV);

	// ========================================
	// FSM
	// ========================================
	always_comb
	begin
		state_nx = state;
		case (state)
			IDLE:
				if (accept)
					state_nx = is_div ? DSTART : EXEC;
			EXEC: state_nx = IDLE;
			DSTART: state_nx = DSTEP;
			DSTEP:
				if (last)
					state_nx = DFIN;
			DFIN: state_nx = IDLE;
			default: state_nx = IDLE;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state <= IDLE;
			sel_div <= 1'b0;
			done <= 1'b0;
		end
		else
		begin
			state <= state_nx;
			if (accept)
				sel_div <= is_div;
			done <= (state == EXEC) || (state == DFIN);	// Lines up with ALU output
		end
	end

	// Operand latch
	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			op.ir <= ir_in;
			op.a <= a_in;
			op.b <= b_in;
			op.c <= c_in;
			op.imm <= imm_in;
		end
	end

	assign alu_go    = (state == EXEC);
	assign div_start = (state == DSTART);
	assign div_step  = (state == DSTEP);

endmodule

//--- hdl/sau_top.sv
`timescale 1ns/1ps

module sau_top #(
	parameter int WID = 64
) (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  ld,
	input  sau_isa_pkg::instr_t   ir,
	input  logic [WID-1:0]        a,
	input  logic [WID-1:0]        b,
	input  logic [WID-1:0]        c,
	input  logic [WID-1:0]        imm,
	output logic [WID-1:0]        result,
	output sau_fault_pkg::cause_t cause,
	output logic                  done,
	output logic                  busy
);
	import sau_isa_pkg::*;
	import sau_fault_pkg::*;

	logic           alu_go;
	logic           div_start;
	logic           div_step;
	logic           sel_div;
	logic           last;
	logic [WID-1:0] alu_res;
	cause_t         alu_exc;
	logic [WID-1:0] quot;
	logic [WID-1:0] rem;
	logic           dbz;
	logic [WID-1:0] div_res;

	sau_op_if #(.WID(WID)) opif ();

	sau_seq #(.WID(WID)) u_seq (
		.clk       (clk),
		.rst       (rst),
		.ld        (ld),
		.ir_in     (ir),
		.a_in      (a),
		.b_in      (b),
		.c_in      (c),
		.imm_in    (imm),
		.last      (last),
		.op        (opif.src),
		.alu_go    (alu_go),
		.div_start (div_start),
		.div_step  (div_step),
		.sel_div   (sel_div),
		.done      (done),
		.busy      (busy)
	);

	// Counter loads on the same cycle as the divider
	sau_step_counter #(.WID(WID)) u_cnt (
		.clk  (clk),
		.rst  (rst),
		.load (div_start),
		.step (div_step),
		.last (last)
	);

	sau_alu #(.WID(WID)) u_alu (
		.clk (clk),
		.rst (rst),
		.go  (alu_go),
		.op  (opif.alu),
		.res (alu_res),
		.exc (alu_exc)
	);

	sau_divider #(.WID(WID)) u_div (
		.clk   (clk),
		.rst   (rst),
		.start (div_start),
		.step  (div_step),
		.op    (opif.div),
		.quot  (quot),
		.rem   (rem),
		.dbz   (dbz)
	);

	// ========================================
	// Output select
	// ========================================
	assign div_res = (opif.ir.fn == DF_REM) ? rem : quot;
	assign result  = sel_div ? div_res : alu_res;
	assign cause   = sel_div ? (dbz ? FLT_DBZ : FLT_NONE) : alu_exc;

endmodule

//--- bench/sau_clkgen.sv
`timescale 1ns/1ps

module sau_clkgen #(
	parameter realtime HALF       = 4.0,
	parameter int      RST_CYCLES = 16
) (
	output logic clk,
	output logic rst
);

	initial
	begin
		clk = 1'b0;
		forever #(HALF) clk = ~clk;
	end

	initial
	begin
		rst = 1'b1;
		repeat (RST_CYCLES) @(posedge clk);
		rst <= 1'b0;	// Released on an edge like any other input
	end

endmodule

//--- bench/sau_props.sv
`timescale 1ns/1ps

module sau_props #(
	parameter int WID = 64
) (
	input logic                clk,
	input logic                rst,
	input logic                ld,
	input sau_isa_pkg::instr_t ir,
	input logic                done,
	input logic                busy
);
	import sau_isa_pkg::*;

	logic accept;
	int   fail_count = 0;	// Failed assertions so far

	assign accept = ld && !busy;	// Same rule as the sequencer

	// ========================================
	// Protocol and latency
	// ========================================
	done_pulse: assert property (@(posedge clk) disable iff (rst) done |=> !done)
	else
	begin
		fail_count++;
		$error("done stayed high for two cycles");
	end

	idle_after_reset: assert property (@(posedge clk) rst |=> !busy)
	else
	begin
		fail_count++;
		$error("busy high after a reset cycle");
	end

	alu_latency: assert property (@(posedge clk) disable iff (rst)
		accept && ir.opcode != OP_DIV |=> !done ##1 done)
	else
	begin
		fail_count++;
		$error("single-cycle done not two cycles after ld");
	end

	// Latch, start, WID steps, finish
	div_latency: assert property (@(posedge clk) disable iff (rst)
		accept && ir.opcode == OP_DIV |=> (!done) [*(WID + 2)] ##1 done)
	else
	begin
		fail_count++;
		$error("divide done not WID+3 cycles after ld");
	end

endmodule

bind sau_top sau_props #(.WID(WID)) u_props (
	.clk  (clk),
	.rst  (rst),
	.ld   (ld),
	.ir   (ir),
	.done (done),
	.busy (busy)
);

//--- bench/sau_tb.sv
`timescale 1ns/1ps

module sau_tb;
	import sau_isa_pkg::*;
	import sau_fault_pkg::*;

	localparam int WID = 64;

	typedef struct {
		instr_t         ir;
		logic [WID-1:0] a;
		logic [WID-1:0] b;
		logic [WID-1:0] c;
		logic [WID-1:0] imm;
		logic [WID-1:0] exp_res;
		cause_t         exp_cause;
	} row_t;

	logic           clk;
	logic           rst;
	logic           ld;
	instr_t         ir;
	logic [WID-1:0] a;
	logic [WID-1:0] b;
	logic [WID-1:0] c;
	logic [WID-1:0] imm;
	logic [WID-1:0] result;
	cause_t         cause;
	logic           done;
	logic           busy;

	row_t        rows[$];	// Stimulus table
	logic [31:0] rng;
	int          err_res = 0;
	int          err_cause = 0;
	int          err_ctl = 0;
	int          timeouts = 0;

	sau_clkgen u_clk (.clk(clk), .rst(rst));

	sau_top #(.WID(WID)) dut (
		.clk    (clk),
		.rst    (rst),
		.ld     (ld),
		.ir     (ir),
		.a      (a),
		.b      (b),
		.c      (c),
		.imm    (imm),
		.result (result),
		.cause  (cause),
		.done   (done),
		.busy   (busy)
	);

	// ========================================
	// Random source and reference model
	// ========================================
	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic logic [WID-1:0] rand_word();
		logic [WID-1:0] w;
		int             k;
		w = '0;
		for (k = 0; k < WID / 32; k++)
		begin
			rng = xorshift(rng);
			w = (w << 32) | rng;
		end
		return w;
	endfunction

	function automatic logic [WID-1:0] count_bits(input logic [WID-1:0] x, input logic [2:0] fn);
		int n;
		int i;
		n = 0;
		case (fn)
			3'd0: for (i = WID - 1; i >= 0 && x[i]; i--) n++;	// CLO
			3'd1: for (i = WID - 1; i >= 0 && !x[i]; i--) n++;	// CLZ
			3'd2: for (i = 0; i < WID; i++) n += x[i];
			default: for (i = 0; i < WID && !x[i]; i++) n++;	// CTZ
		endcase
		return n;
	endfunction

	function automatic row_t reference_model(input row_t r);
		logic [WID-1:0] bo;
		logic [WID-1:0] s;
		int             sh;
		logic           lo_ok;
		logic           hi_ok;
		logic           pass;
		bo = r.ir.isimm ? r.imm : r.b;
		sh = bo % WID;
		r.exp_res = '0;
		r.exp_cause = FLT_NONE;
		case (r.ir.opcode)
			OP_ADD:
			begin
				s = r.a + bo;
				r.exp_res = (r.ir.fn == 3'd2 && s[WID-1]) ? -s : s;
			end
			OP_AND, OP_OR, OP_XOR:
			begin
				if (r.ir.fn == 3'd2)
					bo = ~bo;
				if (r.ir.opcode == OP_AND)
					s = r.a & bo;
				else if (r.ir.opcode == OP_OR)
					s = r.a | bo;
				else
					s = r.a ^ bo;
				r.exp_res = (r.ir.fn == 3'd1) ? ~s : s;
			end
			OP_SUBF: r.exp_res = bo - r.a;
			OP_SHIFT:
				case (r.ir.fn)
					3'd0: r.exp_res = r.a << sh;
					3'd1: r.exp_res = r.a >> sh;
					3'd2: r.exp_res = $signed(r.a) >>> sh;
					3'd3: r.exp_res = (sh == 0) ? r.a : (r.a << sh) | (r.a >> (WID - sh));
					default: r.exp_res = (sh == 0) ? r.a : (r.a >> sh) | (r.a << (WID - sh));
				endcase
			OP_CNT: r.exp_res = count_bits(r.a, r.ir.fn);
			OP_MOV: r.exp_res = ((r.a == '0) == (r.ir.fn == 3'd4)) ? bo : r.c;
			OP_CMP:
			begin
				r.exp_res[0] = (r.a == bo);
				r.exp_res[1] = ($signed(r.a) < $signed(bo));
				r.exp_res[2] = (r.a < bo);
			end
			OP_CHK:
			begin
				lo_ok = r.ir.fn[1] ? (r.a > r.b) : (r.a >= r.b);
				hi_ok = r.ir.fn[0] ? (r.a <= r.c) : (r.a < r.c);
				pass = r.ir.fn[2] ^ (lo_ok && hi_ok);	// Bit 2 asks for out of range
				r.exp_res[0] = pass;
				if (!pass)
					r.exp_cause = FLT_CHK;
			end
			OP_LOADA: r.exp_res = r.a + r.imm + (r.b << r.ir.sc);
			OP_DIV:
				if (bo == '0)
				begin
					r.exp_res = (r.ir.fn == 3'd1) ? r.a : '1;
					r.exp_cause = FLT_DBZ;
				end
				else
					r.exp_res = (r.ir.fn == 3'd1) ? r.a % bo : r.a / bo;
			OP_NOP: r.exp_res = r.c;
			default:
			begin
				r.exp_res = {(WID / 16){16'hDEAD}};
				r.exp_cause = FLT_UNIMP;
			end
		endcase
		return r;
	endfunction

	function automatic row_t make_row(input opcode_t opc, input logic [2:0] fn,
			input logic isimm, input logic [1:0] sc, input logic [WID-1:0] ra,
			input logic [WID-1:0] rb, input logic [WID-1:0] rc, input logic [WID-1:0] rimm);
		row_t r;
		r.ir.opcode = opc;
		r.ir.fn = fn;
		r.ir.isimm = isimm;
		r.ir.sc = sc;
		r.ir.amt = 5'd0;
		r.a = ra;
		r.b = rb;
		r.c = rc;
		r.imm = rimm;
		return reference_model(r);
	endfunction

	task automatic put_literal(input row_t r, input logic [WID-1:0] res, input cause_t flt);
		r.exp_res = res;
		r.exp_cause = flt;
		rows.push_back(r);
	endtask

	// ========================================
	// Stimulus table
	// ========================================
	task automatic build_table();
		logic [WID-1:0] x;
		logic [WID-1:0] y;
		logic [WID-1:0] z;
		int             i;
		int             f;
		int             amt [5];
		int             probe [5];
		probe = '{99, 100, 150, 200, 201};
		// Hand-worked expectations
		put_literal(make_row(OP_ADD, 3'd0, 1'b0, 2'd0, 5, 7, 0, 0), 12, FLT_NONE);
		put_literal(make_row(OP_ADD, 3'd2, 1'b0, 2'd0, -9, 2, 0, 0), 7, FLT_NONE);
		put_literal(make_row(OP_SUBF, 3'd0, 1'b0, 2'd0, 3, 10, 0, 0), 7, FLT_NONE);
		put_literal(make_row(OP_CMP, 3'd0, 1'b0, 2'd0, '1, 1, 0, 0), 2, FLT_NONE);
		put_literal(make_row(OP_CNT, 3'd1, 1'b0, 2'd0, 0, 0, 0, 0), WID, FLT_NONE);
		put_literal(make_row(OP_CNT, 3'd3, 1'b0, 2'd0, 0, 0, 0, 0), WID, FLT_NONE);
		put_literal(make_row(OP_CNT, 3'd0, 1'b0, 2'd0, '1, 0, 0, 0), WID, FLT_NONE);
		put_literal(make_row(OP_CNT, 3'd2, 1'b0, 2'd0, '1, 0, 0, 0), WID, FLT_NONE);
		put_literal(make_row(OP_NOP, 3'd0, 1'b0, 2'd0, 1, 2, 64'h0123_4567_89ab_cdef, 3),
			64'h0123_4567_89ab_cdef, FLT_NONE);
		put_literal(make_row(opcode_t'(5'd20), 3'd0, 1'b0, 2'd0, 1, 2, 3, 4),
			{(WID / 16){16'hDEAD}}, FLT_UNIMP);
		put_literal(make_row(OP_DIV, 3'd0, 1'b0, 2'd0, 100, 7, 0, 0), 14, FLT_NONE);
		put_literal(make_row(OP_DIV, 3'd1, 1'b0, 2'd0, 100, 7, 0, 0), 2, FLT_NONE);
		put_literal(make_row(OP_DIV, 3'd0, 1'b0, 2'd0, 12345, 0, 0, 0), '1, FLT_DBZ);
		put_literal(make_row(OP_DIV, 3'd1, 1'b0, 2'd0, 12345, 0, 0, 0), 12345, FLT_DBZ);
		for (i = 0; i < 6; i++)
		begin
			x = rand_word();
			y = rand_word();
			rows.push_back(make_row(OP_ADD, 3'd0, 1'b0, 2'd0, x, y, 0, 0));
			rows.push_back(make_row(OP_ADD, 3'd0, 1'b1, 2'd0, x, 0, 0, y));	// Add-immediate
			rows.push_back(make_row(OP_ADD, 3'd2, 1'b0, 2'd0, x, y, 0, 0));
			rows.push_back(make_row(OP_SUBF, 3'd0, i[0], 2'd0, x, y, 0, ~y));
			for (f = 0; f < 3; f++)
			begin
				rows.push_back(make_row(OP_AND, 3'(f), 1'b0, 2'd0, x, y, 0, 0));
				rows.push_back(make_row(OP_OR, 3'(f), 1'b0, 2'd0, x, y, 0, 0));
				rows.push_back(make_row(OP_XOR, 3'(f), 1'b1, 2'd0, x, 0, 0, y));
			end
		end
		amt[0] = 0;
		amt[1] = 1;
		amt[2] = WID - 1;
		amt[3] = rand_word() % WID;
		amt[4] = rand_word() % WID;
		for (i = 0; i < 5; i++)
			for (f = 0; f < 5; f++)
			begin
				x = rand_word();
				y = (rand_word() / WID) * WID + amt[i];	// Upper bits must be ignored
				rows.push_back(make_row(OP_SHIFT, 3'(f), 1'b0, 2'd0, x, y, 0, 0));
			end
		for (i = 0; i < 5; i++)
		begin
			x = (i == 0) ? '0 : (i == 1) ? '1 : (i == 2) ? 64'h00F0_0000_0000_0100 : rand_word();
			for (f = 0; f < 4; f++)
				rows.push_back(make_row(OP_CNT, 3'(f), 1'b0, 2'd0, x, 0, 0, 0));
		end
		// Equal, signed-less only, unsigned-less only, both
		x = rand_word();
		rows.push_back(make_row(OP_CMP, 3'd0, 1'b1, 2'd0, x, 0, 0, x));
		rows.push_back(make_row(OP_CMP, 3'd0, 1'b0, 2'd0, -5, 3, 0, 0));
		rows.push_back(make_row(OP_CMP, 3'd0, 1'b0, 2'd0, 3, -5, 0, 0));
		rows.push_back(make_row(OP_CMP, 3'd0, 1'b0, 2'd0, 2, 9, 0, 0));
		x = rand_word();
		y = rand_word();
		for (f = 4; f < 6; f++)
		begin
			rows.push_back(make_row(OP_MOV, 3'(f), 1'b0, 2'd0, 0, x, y, 0));
			rows.push_back(make_row(OP_MOV, 3'(f), 1'b0, 2'd0, 7, x, y, 0));
		end
		for (i = 0; i < 4; i++)
		begin
			x = rand_word();
			y = rand_word();
			z = rand_word();
			rows.push_back(make_row(OP_LOADA, 3'd0, 1'b0, 2'(i), x, y, 0, z));
		end
		for (f = 0; f < 8; f++)
			for (i = 0; i < 5; i++)
				rows.push_back(make_row(OP_CHK, 3'(f), 1'b0, 2'd0, probe[i], 100, 200, 0));
		for (i = 0; i < 4; i++)
		begin
			x = rand_word();
			y = rand_word() >> (8 + 12 * i);
			rows.push_back(make_row(OP_DIV, 3'd0, 1'b0, 2'd0, x, y, 0, 0));
			rows.push_back(make_row(OP_DIV, 3'd1, 1'b0, 2'd0, x, y, 0, 0));
		end
		rows.push_back(make_row(OP_DIV, 3'd0, 1'b1, 2'd0, rand_word(), 0, 0, 64'd1000003));
	endtask

	// ========================================
	// Compare tasks
	// ========================================
	task automatic check_result(input logic [WID-1:0] got, input logic [WID-1:0] exp,
			input string what);
		if (got !== exp)
		begin
			err_res++;
			$display("** Error at %0t: %s result %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_cause(input cause_t got, input cause_t exp, input string what);
		if (got !== exp)
		begin
			err_cause++;
			$display("** Error at %0t: %s cause %0d, expected %0d", $time, what, got, exp);
		end
	endtask

	task automatic check_latency(input int got, input int exp, input string what);
		if (got != exp)
		begin
			err_ctl++;
			$display("** Error at %0t: %s done after %0d cycles, expected %0d",
				$time, what, got, exp);
		end
	endtask

	task automatic check_flag(input logic got, input logic exp, input string what);
		if (got !== exp)
		begin
			err_ctl++;
			$display("** Error at %0t: %s is %b, expected %b", $time, what, got, exp);
		end
	endtask

	// ========================================
	// Drivers
	// ========================================
	task automatic drive_row(input row_t r);
		ld <= 1'b1;
		ir <= r.ir;
		a <= r.a;
		b <= r.b;
		c <= r.c;
		imm <= r.imm;
	endtask

	// Called on a rising edge, returns on the edge where done is seen
	task automatic run_row(input int idx);
		row_t  r;
		int    k;
		string tag;
		r = rows[idx];
		tag = $sformatf("row %0d (op %0d fn %0d)", idx, r.ir.opcode, r.ir.fn);
		drive_row(r);
		@(posedge clk);
		ld <= 1'b0;
		k = 1;
		while (!done && k < WID + 6)
		begin
			@(posedge clk);
			k++;
			if (!done)
				check_flag(busy, 1'b1, {tag, " busy while running"});
		end
		if (!done)
		begin
			timeouts++;
			$display("%s: the DUT gave no done within %0d cycles", tag, k);
		end
		else
		begin
			check_result(result, r.exp_res, tag);
			check_cause(cause, r.exp_cause, tag);
			check_latency(k - 1, (r.ir.opcode == OP_DIV) ? WID + 3 : 2, tag);
			check_flag(busy, 1'b0, {tag, " busy on done"});
		end
	endtask

	// Second operation issued on the cycle that the divide's done is high
	task automatic overlap_pair(input row_t d, input row_t s);
		int k;
		drive_row(d);
		for (k = 1; k <= WID + 3; k++)
		begin
			@(posedge clk);
			if (k == 1)
				ld <= 1'b0;
		end
		drive_row(s);
		@(posedge clk);
		ld <= 1'b0;
		check_flag(done, 1'b1, "divide done on the overlap cycle");
		check_result(result, d.exp_res, "overlapped divide");
		check_cause(cause, d.exp_cause, "overlapped divide");
		@(posedge clk);
		check_flag(done, 1'b0, "done between overlapped results");
		@(posedge clk);
		check_flag(done, 1'b1, "done of the overlapped single-cycle op");
		check_result(result, s.exp_res, "overlapped single-cycle op");
		check_cause(cause, s.exp_cause, "overlapped single-cycle op");
	endtask

	task automatic watchdog(input int cycles);
		repeat (cycles) @(posedge clk);
		$display("Watchdog: the run was still going after %0d cycles and was stopped", cycles);
		$display("Some tests failed");
		$finish;
	endtask

	initial
	begin
		int limit;
		ld = 1'b0;
		ir = '0;
		a = '0;
		b = '0;
		c = '0;
		imm = '0;
		rng = 32'hc7a9;
		build_table();
		limit = (rows.size() + 2) * (WID + 6) + 40;	// Two more rows for the overlap pair
		fork
			watchdog(limit);
		join_none
		@(posedge clk);
		while (rst)
			@(posedge clk);
		check_flag(done, 1'b0, "done after reset");
		check_flag(busy, 1'b0, "busy after reset");
		check_result(result, '0, "after reset");
		check_cause(cause, FLT_NONE, "after reset");
		foreach (rows[i])
			run_row(i);
		overlap_pair(make_row(OP_DIV, 3'd1, 1'b0, 2'd0, rand_word(), 64'd977, 0, 0),
			make_row(OP_XOR, 3'd1, 1'b0, 2'd0, rand_word(), rand_word(), 0, 0));
		$display("Errors: result %0d, cause %0d, control %0d, assertions %0d, timeouts %0d",
			err_res, err_cause, err_ctl, dut.u_props.fail_count, timeouts);
		if (err_res + err_cause + err_ctl + dut.u_props.fail_count + timeouts == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule

//--- files.f
hdl/sau_isa_pkg.sv
hdl/sau_fault_pkg.sv
hdl/sau_op_if.sv
hdl/sau_bitcnt.sv
hdl/sau_alu.sv
hdl/sau_divider.sv
hdl/sau_step_counter.sv
hdl/sau_seq.sv
hdl/sau_top.sv
bench/sau_clkgen.sv
bench/sau_props.sv
bench/sau_tb.sv
